// File: source/monitor_defs.svh
`ifndef MONITOR_DEFS_SVH
`define MONITOR_DEFS_SVH

// clock cycles between two input samples.
`define SAMPLE_DIV 16

// clock cycles each digit stays lit.
`define SCAN_DIV 4

// number of display digits.
`define DIGITS 8

// scanner buffer depth, also the sender's start credit.
`define CREDITS 2

`endif

// File: source/monitorPkg.sv
`include "monitor_defs.svh"

package monitorPkg;

   // display word, written whole by the source stage and read per nibble by the scanner.
   typedef union packed
   {
      logic [31:0] value;
      logic [`DIGITS-1:0][3:0] digit;   // digit[0] is the least significant nibble.
   } dispWord_u;

   // one of sixteen display sources.
   typedef logic [3:0] srcSel_t;

   // active low, dp in bit 7, segment a in bit 0.
   typedef logic [7:0] segPattern_t;

endpackage

// File: source/dispLinkIf.sv
`timescale 1ns/10ps

interface dispLinkIf import monitorPkg::*; ();

   logic valid;        // word offered this cycle.
   dispWord_u word;
   logic credit;       // one buffer slot freed.

   modport sender
   (
      output valid,
      output word,
      input credit
   );

   modport receiver
   (
      input valid,
      input word,
      output credit
   );

endinterface

// File: source/inputSampler.sv
`timescale 1ns/10ps

`include "monitor_defs.svh"

module inputSampler import monitorPkg::*;
(
   input logic selected_clk,
   input logic res,
   input logic [15:0] sw,
   input logic btnC,
   input logic btnU,
   input logic btnD,
   input logic btnL,
   input logic btnR,
   output srcSel_t displaySel,
   output logic [3:0] testOutSelect,
   output logic [3:0] testRegSelect,
   output logic [31:0] portI,
   output logic [31:0] portJ
);

   localparam int divWidth = (`SAMPLE_DIV > 1) ? $clog2(`SAMPLE_DIV) : 1;

   logic [divWidth-1:0] divCount;
   logic sampleTick;
   logic [15:0] swSample;
   logic [4:0] btnSample;      // L, R, U, D, C from the top down.

   // slow sample tick, one cycle wide.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         divCount <= '0;
         sampleTick <= 1'b0;
      end
      else
      begin
         if (divCount == divWidth'(`SAMPLE_DIV - 1))
            divCount <= '0;
         else
            divCount <= divCount + 1'b1;
         sampleTick <= (divCount == divWidth'(`SAMPLE_DIV - 1));
      end
   end

   // switches and buttons are taken together so no select changes alone.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         swSample <= '0;
         btnSample <= '0;
      end
      else if (sampleTick)
      begin
         swSample <= sw;
         btnSample <= {btnL, btnR, btnU, btnD, btnC};
      end
   end

   assign displaySel = srcSel_t'(swSample[11:8]);
   assign testOutSelect = swSample[7:4];
   assign testRegSelect = swSample[3:0];
   assign portI = {27'd0, btnSample};
   assign portJ = {16'd0, swSample};

   tickIsPulse: assert property (@(posedge selected_clk) disable iff (res)
      sampleTick |=> !sampleTick);

endmodule

// File: source/displaySource.sv
`timescale 1ns/10ps

`include "monitor_defs.svh"

module displaySource import monitorPkg::*;
(
   input logic selected_clk,
   input logic res,
   input srcSel_t displaySel,
   input logic [31:0] portA,
   input logic [31:0] portB,
   input logic [31:0] portC,
   input logic [31:0] portD,
   input logic [31:0] arr,
   input logic [31:0] tmr,
   input logic [31:0] ctr,
   input logic [31:0] testOut,
   input logic [31:0] testReg,
   input logic [31:0] portI,
   input logic [31:0] portJ,
   input logic [31:0] irqs,
   input logic [31:0] mdi,
   input logic [31:0] mdo,
   input logic [31:0] addr,
   dispLinkIf.sender link
);

   localparam int creditWidth = $clog2(`CREDITS + 1);

   logic [31:0] clkTest;
   logic [31:0] selWord;
   logic [creditWidth-1:0] creditCount;
   logic sendNext;

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         clkTest <= '0;
      else
         clkTest <= clkTest + 1'b1;   // free running test count.
   end

   always_comb
   begin
      unique case (displaySel)
         4'd0: selWord = portA;
         4'd1: selWord = portB;
         4'd2: selWord = portC;
         4'd3: selWord = portD;
         4'd4: selWord = clkTest;
         4'd5: selWord = arr;
         4'd6: selWord = tmr;
         4'd7: selWord = ctr;
         4'd8: selWord = testOut;
         4'd9: selWord = testReg;
         4'd10: selWord = portI;
         4'd11: selWord = portJ;
         4'd12: selWord = irqs;
         4'd13: selWord = mdi;
         4'd14: selWord = mdo;
         4'd15: selWord = addr;
      endcase
   end

   // a held credit is spent on the next edge.
   assign sendNext = (creditCount != '0);

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         creditCount <= creditWidth'(`CREDITS);
         link.valid <= 1'b0;
      end
      else
      begin
         creditCount <= creditCount - creditWidth'(sendNext) + creditWidth'(link.credit);
         link.valid <= sendNext;
      end
   end

   always_ff @(posedge selected_clk)
   begin
      link.word.value <= selWord;
   end

   // receiver returns no more credits than it got words.
   creditBound: assert property (@(posedge selected_clk) disable iff (res)
      creditCount <= creditWidth'(`CREDITS));

   noSendAtZero: assert property (@(posedge selected_clk) disable iff (res)
      link.valid |-> $past(creditCount) != '0);

endmodule

// File: source/digitScanner.sv
`timescale 1ns/10ps

`include "monitor_defs.svh"

module digitScanner import monitorPkg::*;
(
   input logic selected_clk,
   input logic res,
   dispLinkIf.receiver link,
   output segPattern_t seg,
   output logic [`DIGITS-1:0] an
);

   localparam int ptrWidth = (`CREDITS > 1) ? $clog2(`CREDITS) : 1;
   localparam int fillWidth = $clog2(`CREDITS + 1);
   localparam int scanWidth = (`SCAN_DIV > 1) ? $clog2(`SCAN_DIV) : 1;
   localparam int digitWidth = $clog2(`DIGITS);

   dispWord_u wordBuf [`CREDITS];
   logic [ptrWidth-1:0] wrPtr;
   logic [ptrWidth-1:0] rdPtr;
   logic [fillWidth-1:0] fillCount;
   logic [scanWidth-1:0] scanCount;
   logic [digitWidth-1:0] digitIdx;
   logic frameEnd;
   logic pop;
   logic started;
   dispWord_u curWord;

   // active low 7-segment code, bit 0 is segment a.
   function automatic logic [6:0] hexToSeg(input logic [3:0] nibble);
      logic [6:0] pattern;
      case (nibble)
         4'h0: pattern = 7'h40;
         4'h1: pattern = 7'h79;
         4'h2: pattern = 7'h24;
         4'h3: pattern = 7'h30;
         4'h4: pattern = 7'h19;
         4'h5: pattern = 7'h12;
         4'h6: pattern = 7'h02;
         4'h7: pattern = 7'h78;
         4'h8: pattern = 7'h00;
         4'h9: pattern = 7'h10;
         4'hA: pattern = 7'h08;
         4'hB: pattern = 7'h03;
         4'hC: pattern = 7'h46;
         4'hD: pattern = 7'h21;
         4'hE: pattern = 7'h06;
         default: pattern = 7'h0E;
      endcase
      return pattern;
   endfunction

   assign frameEnd = (scanCount == scanWidth'(`SCAN_DIV - 1))
                  && (digitIdx == digitWidth'(`DIGITS - 1));
   assign pop = frameEnd && (fillCount != '0);

   // digit and frame timing.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         scanCount <= '0;
         digitIdx <= '0;
         started <= 1'b0;
      end
      else
      begin
         if (scanCount == scanWidth'(`SCAN_DIV - 1))
         begin
            scanCount <= '0;
            digitIdx <= frameEnd ? '0 : digitIdx + 1'b1;
         end
         else
            scanCount <= scanCount + 1'b1;
         if (frameEnd)
            started <= 1'b1;
      end
   end

   // buffer pointers and credit return.
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         fillCount <= '0;
         curWord <= '0;
         link.credit <= 1'b0;
      end
      else
      begin
         if (link.valid)
            wrPtr <= (wrPtr == ptrWidth'(`CREDITS - 1)) ? '0 : wrPtr + 1'b1;
         if (pop)
         begin
            rdPtr <= (rdPtr == ptrWidth'(`CREDITS - 1)) ? '0 : rdPtr + 1'b1;
            curWord <= wordBuf[rdPtr];
         end
         fillCount <= fillCount + fillWidth'(link.valid) - fillWidth'(pop);
         link.credit <= pop;
      end
   end

   always_ff @(posedge selected_clk)
   begin
      if (link.valid)
         wordBuf[wrPtr] <= link.word;
   end

   assign an = started ? ~({{(`DIGITS-1){1'b0}}, 1'b1} << digitIdx) : '1;
   assign seg = started ? {1'b1, hexToSeg(curWord.digit[digitIdx])} : '1;   // dp off.

   // the sender's credits must keep it from overrunning the buffer.
   noWriteWhenFull: assert property (@(posedge selected_clk) disable iff (res)
      link.valid |-> fillCount < fillWidth'(`CREDITS));

   oneDigitLit: assert property (@(posedge selected_clk) disable iff (res)
      started |-> $onehot(~an));

endmodule

// File: source/boardMonitor.sv
`timescale 1ns/10ps

module boardMonitor import monitorPkg::*;
(
   input logic selected_clk,
   input logic res,
   input logic [15:0] sw,
   input logic btnC,
   input logic btnU,
   input logic btnD,
   input logic btnL,
   input logic btnR,
   input logic [31:0] portA,
   input logic [31:0] portB,
   input logic [31:0] portC,
   input logic [31:0] portD,
   input logic [31:0] arr,
   input logic [31:0] tmr,
   input logic [31:0] ctr,
   input logic [31:0] testOut,
   input logic [31:0] testReg,
   input logic [31:0] irqs,
   input logic [31:0] mdi,
   input logic [31:0] mdo,
   input logic [31:0] addr,
   output logic [31:0] portI,
   output logic [31:0] portJ,
   output logic [3:0] testOutSelect,
   output logic [3:0] testRegSelect,
   output logic [15:0] leds,
   output segPattern_t seg,
   output logic [7:0] an
);

   srcSel_t displaySel;

   dispLinkIf dispLink ();

   inputSampler sampler
   (
      .selected_clk(selected_clk),
      .res(res),
      .sw(sw),
      .btnC(btnC),
      .btnU(btnU),
      .btnD(btnD),
      .btnL(btnL),
      .btnR(btnR),
      .displaySel(displaySel),
      .testOutSelect(testOutSelect),
      .testRegSelect(testRegSelect),
      .portI(portI),
      .portJ(portJ)
   );

   displaySource source
   (
      .selected_clk(selected_clk),
      .res(res),
      .displaySel(displaySel),
      .portA(portA),
      .portB(portB),
      .portC(portC),
      .portD(portD),
      .arr(arr),
      .tmr(tmr),
      .ctr(ctr),
      .testOut(testOut),
      .testReg(testReg),
      .portI(portI),
      .portJ(portJ),
      .irqs(irqs),
      .mdi(mdi),
      .mdo(mdo),
      .addr(addr),
      .link(dispLink.sender)
   );

   digitScanner scanner
   (
      .selected_clk(selected_clk),
      .res(res),
      .link(dispLink.receiver),
      .seg(seg),
      .an(an)
   );

   assign leds = portB[15:0];   // low half of port B.

endmodule

// File: test/monitorRef.svh
`ifndef MONITOR_REF_SVH
`define MONITOR_REF_SVH

// hex digit to segments, active low with the dp dark.
function automatic segPattern_t refSeg(input logic [3:0] nibble);
   logic [6:0] lit;   // gfedcba, high means lit.
   case (nibble)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
   endcase
   return {1'b1, ~lit};
endfunction

// buttons L, R, U, D, C from bit 4 down.
function automatic logic [31:0] refPortI();
   return {27'd0, btnL, btnR, btnU, btnD, btnC};
endfunction

function automatic logic [31:0] refPortJ();
   return {16'd0, sw};
endfunction

function automatic logic [31:0] refSource(input srcSel_t sel);
   case (sel)
      4'd10: return refPortI();
      4'd11: return refPortJ();
      default: return srcVal[sel];   // external sources, wired by select.
   endcase
endfunction

task automatic checkSeg(input string name, input segPattern_t expected, input segPattern_t actual);
   if (actual !== expected)
      stopRun($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
endtask

task automatic checkWord(input string name, input logic [31:0] expected, input logic [31:0] actual);
   if (actual !== expected)
      stopRun($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
endtask

task automatic checkRising(input string name, input dispWord_u earlier, input dispWord_u later);
   if (later.value <= earlier.value)
      stopRun($sformatf("FAILED %s: expected above %h, actual %h", name, earlier.value,
                        later.value));
endtask

`endif

// File: test/boardMonitorTb.sv
`timescale 1ns/10ps

`include "monitor_defs.svh"

module boardMonitorTb import monitorPkg::*; ();

   localparam int frameCycles = `DIGITS * `SCAN_DIV;
   localparam int settleCycles = (`CREDITS + 3) * frameCycles + 2 * `SAMPLE_DIV;
   localparam int testCycles = settleCycles + 3 * frameCycles + 2;
   localparam int churnSteps = 20;
   localparam int churnGap = 6;
   localparam int runCycles = 16 + 2 + 17 * testCycles + churnSteps * churnGap;
   localparam int cycleLimit = runCycles + runCycles / 5;

   logic selected_clk;
   logic res;
   logic [15:0] sw;
   logic btnC, btnU, btnD, btnL, btnR;
   logic [31:0] srcVal [16];   // indexed by display select.
   logic [31:0] portI;
   logic [31:0] portJ;
   logic [3:0] testOutSelect;
   logic [3:0] testRegSelect;
   logic [15:0] leds;
   segPattern_t seg;
   logic [7:0] an;

   int seed;
   int cycleCount = 0;
   int frameWraps = 0;
   int lastDigit = 0;
   string testName = "reset";
   logic [31:0] expWord = '0;
   logic watchExact = 1'b0;
   logic watchRising = 1'b0;
   logic scanSeen = 1'b0;
   dispWord_u observedWord = '0;
   dispWord_u prevWord = '0;

   boardMonitor u_dut
   (
      .selected_clk(selected_clk), .res(res), .sw(sw),
      .btnC(btnC), .btnU(btnU), .btnD(btnD), .btnL(btnL), .btnR(btnR),
      .portA(srcVal[0]), .portB(srcVal[1]), .portC(srcVal[2]), .portD(srcVal[3]),
      .arr(srcVal[5]), .tmr(srcVal[6]), .ctr(srcVal[7]),
      .testOut(srcVal[8]), .testReg(srcVal[9]),
      .irqs(srcVal[12]), .mdi(srcVal[13]), .mdo(srcVal[14]), .addr(srcVal[15]),
      .portI(portI), .portJ(portJ), .testOutSelect(testOutSelect),
      .testRegSelect(testRegSelect), .leds(leds), .seg(seg), .an(an)
   );

   task automatic stopRun(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

`include "monitorRef.svh"

   always #4 selected_clk = ~selected_clk;

   always @(posedge selected_clk)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount > cycleLimit)
         stopRun($sformatf("timeout, no verdict after %0d cycles", cycleLimit));
   end

   // index of the one lit digit.
   function automatic int litDigit(input logic [7:0] anodes);
      int i;
      int idx;
      idx = 0;
      for (i = 0; i < `DIGITS; i++)
         if (!anodes[i])
            idx = i;
      return idx;
   endfunction

   // segments back to a nibble, bit 4 set on a match.
   function automatic logic [4:0] decodeSeg(input segPattern_t pattern);
      int n;
      logic [4:0] result;
      result = '0;
      for (n = 0; n < 16; n++)
         if (refSeg(4'(n)) == pattern)
            result = {1'b1, 4'(n)};
      return result;
   endfunction

   always @(posedge selected_clk)
   begin : watchDisplay
      int k;
      logic [4:0] decoded;
      checkWord("leds", {16'd0, srcVal[1][15:0]}, {16'd0, leds});
      if (!scanSeen && an == '1)
         checkSeg("blank before first frame", 8'hFF, seg);
      else if (!$onehot(~an))
         stopRun($sformatf("anode pattern %b does not light exactly one digit", an));
      else
      begin
         scanSeen = 1'b1;
         k = litDigit(an);
         if (k != lastDigit && k != (lastDigit + 1) % `DIGITS)
            stopRun($sformatf("digit %0d lit right after digit %0d, out of scan order",
                              k, lastDigit));
         if (watchExact)
            checkSeg($sformatf("%s digit %0d", testName, k), refSeg(expWord[k*4 +: 4]), seg);
         if ((watchExact || watchRising) && k == 0 && lastDigit == `DIGITS - 1)
         begin
            frameWraps = frameWraps + 1;   // first frame seen may be partial.
            if (watchRising && frameWraps >= 3)
               checkRising(testName, prevWord, observedWord);
            prevWord = observedWord;
         end
         if (watchRising)
         begin
            decoded = decodeSeg(seg);
            if (!decoded[4])
               stopRun($sformatf("segment pattern %h is no hex digit", seg));
            observedWord.digit[k] = decoded[3:0];
         end
         lastDigit = k;
      end
   end

   task automatic runTest(input string name, input srcSel_t sel, input bit churn);
      int i;
      @(negedge selected_clk);
      for (i = 0; i < 16; i++)
         srcVal[i] = $random(seed);
      sw = 16'($random(seed));
      {btnL, btnR, btnU, btnD, btnC} = 5'($random(seed));
      for (i = 0; churn && i < churnSteps; i++)
      begin
         sw[11:8] = 4'($random(seed));   // quicker than a frame.
         repeat (churnGap) @(negedge selected_clk);
      end
      sw[11:8] = sel;
      repeat (2 * `SAMPLE_DIV) @(negedge selected_clk);
      checkWord({name, " portI"}, refPortI(), portI);
      checkWord({name, " portJ"}, refPortJ(), portJ);
      checkWord({name, " test selects"}, {24'd0, sw[7:4], sw[3:0]},
                {24'd0, testOutSelect, testRegSelect});
      repeat (settleCycles - 2 * `SAMPLE_DIV) @(negedge selected_clk);
      testName = name;
      expWord = refSource(sel);
      watchExact = (sel != 4'd4);
      watchRising = (sel == 4'd4);   // clock test count only has to climb.
      frameWraps = 0;
      while (frameWraps < 3)
         @(negedge selected_clk);
      watchExact = 1'b0;
      watchRising = 1'b0;
   endtask

   initial
   begin
      int s;
      selected_clk = 1'b0;
      res = 1'b1;
      sw = '1;   // inputs high through reset, outputs must still read zero.
      {btnL, btnR, btnU, btnD, btnC} = '1;
      for (s = 0; s < 16; s++)
         srcVal[s] = '0;
      seed = 32'hc32d;
      repeat (16) @(negedge selected_clk);
      res = 1'b0;
      repeat (2) @(negedge selected_clk);   // still ahead of the first sample.
      checkWord("reset portI", 32'd0, portI);
      checkWord("reset portJ", 32'd0, portJ);
      checkWord("reset test selects", 32'd0, {24'd0, testOutSelect, testRegSelect});
      for (s = 0; s < 16; s++)
         runTest($sformatf("select %0d", s), srcSel_t'(s), 1'b0);
      runTest("changing selects", 4'd13, 1'b1);
      $display("TEST OK");
      $finish;
   end

endmodule

// File: files.f
+incdir+source
+incdir+test
source/monitorPkg.sv
source/dispLinkIf.sv
source/inputSampler.sv
source/displaySource.sv
source/digitScanner.sv
source/boardMonitor.sv
test/boardMonitorTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module boardMonitorTb \
   -o boardMonitorSim > build.log 2>&1 && ./obj_dir/boardMonitorSim > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
